/* rtl/acq_fsm.sv */
`timescale 1ns/1ps

module acq_fsm #(
	parameter int BUF_DEPTH = 64                  // header plus bursts must fit
) (
	input  logic                 clk,
	input  logic                 rst,
	input  chan_pkg::acq_cfg_t   acq_cfg,         // burst counts per fill type
	input  logic [1:0]           acq_enable,      // fill type code, 0 disables
	input  logic                 acq_trig,        // level, rising edge starts a fill
	input  logic                 acq_reset,       // abort back to idle
	input  logic                 readout_pause,   // hold before the next word
	input  logic                 adc_valid,       // a burst is on adc_data
	input  logic                 cnt_at_limit,    // address at the last word
	input  logic                 word_ack,        // from readout_link
	output chan_pkg::fill_type_t fill_type,       // to the header
	output chan_pkg::burst_cnt_t num_bursts,      // to the header
	output logic                 cnt_clear,
	output logic                 cnt_inc,
	output chan_pkg::burst_cnt_t cnt_limit,
	output logic                 buf_we,
	output logic                 buf_wdata_sel,   // 1 picks the header
	output logic                 hdr_capture,
	output logic                 fill_done,       // bumps the fill number
	output logic                 word_req,
	output logic                 last_word,
	output logic                 acq_done
);

	import chan_pkg::*;

	acq_state_t state, next;
	logic       trig_q;                           // acq_trig one cycle back
	logic       trig_rise;
	fill_type_t type_q;                           // latched at the trigger
	burst_cnt_t bursts_q;                         // latched at the trigger
	burst_cnt_t raw_bursts;                       // config count for acq_enable
	burst_cnt_t sel_bursts;                       // clamped to the buffer

	assign trig_rise = acq_trig && !trig_q;

	//////////////////////////////////////////////////
	// burst count for the requested fill type

	always_comb begin
		case (fill_type_t'(acq_enable))
			FILL_MUON:  raw_bursts = acq_cfg.num_muon_bursts;
			FILL_LASER: raw_bursts = acq_cfg.num_laser_bursts;
			FILL_PED:   raw_bursts = acq_cfg.num_ped_bursts;
			default:    raw_bursts = '0;
		endcase
	end

	// address 0 holds the header so only BUF_DEPTH-1 bursts fit
	assign sel_bursts = (int'(raw_bursts) > BUF_DEPTH - 1) ?
		burst_cnt_t'(BUF_DEPTH - 1) : raw_bursts;

	// in idle the header generator sees the live selection
	assign fill_type  = (state == S_IDLE) ? fill_type_t'(acq_enable) : type_q;
	assign num_bursts = (state == S_IDLE) ? sel_bursts : bursts_q;
	assign cnt_limit  = bursts_q;

	//////////////////////////////////////////////////
	// state and latched fill parameters

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= S_IDLE;
			trig_q   <= 1'b0;
			type_q   <= FILL_NONE;
			bursts_q <= '0;
		end else begin
			state  <= next;
			trig_q <= acq_trig;
			if (hdr_capture) begin
				type_q   <= fill_type_t'(acq_enable);
				bursts_q <= sel_bursts;
			end
		end
	end

	//////////////////////////////////////////////////
	// next state and strobes

	always_comb begin
		next          = state;
		cnt_clear     = 1'b0;
		cnt_inc       = 1'b0;
		buf_we        = 1'b0;
		buf_wdata_sel = 1'b0;
		hdr_capture   = 1'b0;
		fill_done     = 1'b0;
		case (state)
			S_IDLE: if (trig_rise && acq_enable != 2'd0) begin
				hdr_capture = 1'b1;
				cnt_clear   = 1'b1;               // header goes to address 0
				next        = S_HEADER;
			end
			S_HEADER: begin
				buf_we        = 1'b1;
				buf_wdata_sel = 1'b1;
				if (cnt_at_limit) begin
					next = S_READ;            // header-only fill, addr already 0
				end else begin
					cnt_inc = 1'b1;
					next    = S_CAPTURE;
				end
			end
			S_CAPTURE: if (adc_valid) begin
				buf_we = 1'b1;
				if (cnt_at_limit) begin
					cnt_clear = 1'b1;         // rewind for readout
					next      = S_READ;
				end else begin
					cnt_inc = 1'b1;
				end
			end
			S_READ: if (!readout_pause && !word_ack) begin
				next = S_SEND;                    // rdata valid next cycle
			end
			S_SEND: if (word_ack) begin
				if (cnt_at_limit) begin
					fill_done = 1'b1;
					next      = S_DONE;
				end else begin
					cnt_inc = 1'b1;
					next    = S_READ;
				end
			end
			S_DONE: if (!word_ack) begin
				next = S_IDLE;                    // link back in idle
			end
			default: next = S_IDLE;
		endcase
		if (acq_reset) begin
			next        = S_IDLE;                 // abort, fill number untouched
			buf_we      = 1'b0;
			hdr_capture = 1'b0;
			fill_done   = 1'b0;
		end
	end

	assign word_req  = (state == S_SEND);
	assign last_word = (state == S_SEND) && cnt_at_limit;
	assign acq_done  = (state == S_READ) || (state == S_SEND);

endmodule

/* rtl/burst_counter.sv */
`timescale 1ns/1ps

module burst_counter (
	input  logic               clk,
	input  logic               rst,
	input  logic               cnt_clear,     // back to address 0
	input  logic               cnt_inc,       // step to the next address
	input  chan_pkg::burst_cnt_t cnt_limit,   // last address of the fill
	output chan_pkg::burst_cnt_t addr,        // shared write and read address
	output logic               cnt_at_limit   // addr sits on the last address
);

	//////////////////////////////////////////////////
	// address register

	// one address serves capture and readout
	// since the two never overlap
	always_ff @(posedge clk) begin
		if (rst) begin
			addr <= '0;
		end else if (cnt_clear) begin
			addr <= '0;               // clear wins over inc
		end else if (cnt_inc) begin
			addr <= addr + 1'b1;      // wraps at 64, limit stops it first
		end
	end

	//////////////////////////////////////////////////
	// terminal flag

	// straight from the register so the fsm sees it
	// in the same cycle as the address
	assign cnt_at_limit = (addr == cnt_limit); // header-only fill hits at 0

endmodule

/* rtl/chan_pkg.sv */
package chan_pkg;

	//////////////////////////////////////////////////
	// widths of the channel data paths

	localparam int WORD_W      = 128;             // buffer word, header or samples
	localparam int LINK_W      = 32;              // one part on the readout link
	localparam int CNT_W       = 6;               // burst count and buffer address
	localparam int FILL_NUM_W  = 24;              // fill number counter
	localparam int TAG_W       = 16;              // channel tag in the header
	localparam int FILL_TYPE_W = 2;               // same width as acq_enable

	localparam int PARTS_PER_WORD = WORD_W / LINK_W; // 4 link parts per buffer word

	// header bits left over after the named fields
	localparam int HDR_PAD_W = WORD_W - FILL_NUM_W - TAG_W - FILL_TYPE_W - CNT_W;

	//////////////////////////////////////////////////
	// plain vector types

	typedef logic [WORD_W-1:0]     word_t;        // header word or 8 x 16 bit samples
	typedef logic [LINK_W-1:0]     link_t;        // readout part
	typedef logic [CNT_W-1:0]      burst_cnt_t;   // bursts per fill or buffer address
	typedef logic [FILL_NUM_W-1:0] fill_num_t;    // running fill number
	typedef logic [TAG_W-1:0]      tag_t;         // channel tag

	//////////////////////////////////////////////////
	// enums

	// codes follow acq_enable from the master
	typedef enum logic [FILL_TYPE_W-1:0] {
		FILL_NONE  = 2'd0,                    // not enabled, triggers ignored
		FILL_MUON  = 2'd1,
		FILL_LASER = 2'd2,
		FILL_PED   = 2'd3                     // pedestal
	} fill_type_t;

	typedef enum logic [2:0] {
		S_IDLE,                               // waiting for a trigger
		S_HEADER,                             // header word goes to address 0
		S_CAPTURE,                            // one burst per adc_valid
		S_READ,                               // buffer read in flight
		S_SEND,                               // word handed to the link
		S_DONE                                // closing the last word handshake
	} acq_state_t;

	//////////////////////////////////////////////////
	// structs

	typedef struct packed {
		tag_t       channel_tag;              // copied into every header
		burst_cnt_t num_muon_bursts;
		burst_cnt_t num_laser_bursts;
		burst_cnt_t num_ped_bursts;
		fill_num_t  initial_fill_num;         // loaded on initial_fill_num_wr
	} acq_cfg_t;

	typedef struct packed {
		fill_num_t             fill_num;      // top bits of the word
		tag_t                  channel_tag;
		fill_type_t            fill_type;
		burst_cnt_t            num_bursts;
		logic [HDR_PAD_W-1:0]  pad;           // always zero
	} header_t;

endpackage

/* rtl/channel_acq_top.sv */
`timescale 1ns/1ps

module channel_acq_top #(
	parameter int BUF_DEPTH = 64                    // at most 64, burst_cnt_t range
) (
	input  logic                clk,
	input  logic                rst,                // synchronous, active high
	input  chan_pkg::acq_cfg_t  acq_cfg,            // host configuration
	input  logic                initial_fill_num_wr,
	input  logic [1:0]          acq_enable,         // fill type, 0 disables
	input  logic                acq_trig,
	input  logic                acq_reset,
	input  logic                readout_pause,
	input  chan_pkg::word_t     adc_data,
	input  logic                adc_valid,
	output logic                acq_done,
	output chan_pkg::fill_num_t fill_num,
	output chan_pkg::link_t     tx_data,
	output logic                tx_req,
	output logic                tx_last,
	input  logic                tx_ack              // from the master
);

	import chan_pkg::*;

	fill_type_t fill_type;                          // fsm to header
	burst_cnt_t num_bursts;
	logic       cnt_clear, cnt_inc;
	burst_cnt_t cnt_limit;
	logic       cnt_at_limit;
	burst_cnt_t addr;                               // shared buffer address
	logic       buf_we, buf_wdata_sel;
	logic       hdr_capture, fill_done;
	word_t      header;                             // header to buffer
	word_t      rdata;                              // buffer to link
	logic       word_req, word_ack, last_word;      // fsm to link handshake

	//////////////////////////////////////////////////
	// control

	acq_fsm #(
		.BUF_DEPTH(BUF_DEPTH)
	) i_acq_fsm (
		.clk(clk), .rst(rst),
		.acq_cfg(acq_cfg),
		.acq_enable(acq_enable),
		.acq_trig(acq_trig),
		.acq_reset(acq_reset),
		.readout_pause(readout_pause),
		.adc_valid(adc_valid),
		.cnt_at_limit(cnt_at_limit),
		.word_ack(word_ack),
		.fill_type(fill_type),
		.num_bursts(num_bursts),
		.cnt_clear(cnt_clear),
		.cnt_inc(cnt_inc),
		.cnt_limit(cnt_limit),
		.buf_we(buf_we),
		.buf_wdata_sel(buf_wdata_sel),
		.hdr_capture(hdr_capture),
		.fill_done(fill_done),
		.word_req(word_req),
		.last_word(last_word),
		.acq_done(acq_done)
	);

	burst_counter i_burst_counter (
		.clk(clk), .rst(rst),
		.cnt_clear(cnt_clear),
		.cnt_inc(cnt_inc),
		.cnt_limit(cnt_limit),
		.addr(addr),
		.cnt_at_limit(cnt_at_limit)
	);

	fill_header_gen i_fill_header_gen (
		.clk(clk), .rst(rst),
		.acq_cfg(acq_cfg),
		.initial_fill_num_wr(initial_fill_num_wr),
		.fill_type(fill_type),
		.num_bursts(num_bursts),
		.hdr_capture(hdr_capture),
		.fill_done(fill_done),
		.fill_num(fill_num),
		.header(header)
	);

	//////////////////////////////////////////////////
	// data path

	fill_buffer #(
		.BUF_DEPTH(BUF_DEPTH)
	) i_fill_buffer (
		.clk(clk),
		.addr(addr),
		.we(buf_we),
		.wdata_sel(buf_wdata_sel),
		.header(header),
		.adc_data(adc_data),
		.rdata(rdata)
	);

	readout_link i_readout_link (
		.clk(clk), .rst(rst),
		.word(rdata),
		.word_req(word_req),
		.last_word(last_word),
		.tx_ack(tx_ack),
		.word_ack(word_ack),
		.tx_data(tx_data),
		.tx_req(tx_req),
		.tx_last(tx_last)
	);

endmodule

/* rtl/fill_buffer.sv */
`timescale 1ns/1ps

module fill_buffer #(
	parameter int BUF_DEPTH = 64              // words, at most 64
) (
	input  logic                 clk,
	input  chan_pkg::burst_cnt_t addr,        // from burst_counter
	input  logic                 we,          // write this cycle
	input  logic                 wdata_sel,   // 1 header, 0 adc samples
	input  chan_pkg::word_t      header,      // registered header word
	input  chan_pkg::word_t      adc_data,    // eight samples
	output chan_pkg::word_t      rdata        // one cycle after addr
);

	import chan_pkg::*;

	word_t mem [BUF_DEPTH];                   // local stand-in for the ddr3 store
	word_t wdata;                             // selected write word

	//////////////////////////////////////////////////
	// write data select

	// header only ever lands on address 0
	// samples fill the addresses above it
	assign wdata = wdata_sel ? header : adc_data;

	//////////////////////////////////////////////////
	// single port array

	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= wdata;       // fsm keeps addr below BUF_DEPTH
		end
		rdata <= mem[addr];               // read first, old data on a collision
	end

endmodule

/* rtl/fill_header_gen.sv */
`timescale 1ns/1ps

module fill_header_gen (
	input  logic                   clk,
	input  logic                   rst,
	input  chan_pkg::acq_cfg_t     acq_cfg,             // tag and initial fill number
	input  logic                   initial_fill_num_wr, // load strobe from the host
	input  chan_pkg::fill_type_t   fill_type,           // type of the fill being started
	input  chan_pkg::burst_cnt_t   num_bursts,          // bursts of that fill
	input  logic                   hdr_capture,         // trigger accepted
	input  logic                   fill_done,           // readout finished
	output chan_pkg::fill_num_t    fill_num,
	output chan_pkg::word_t        header
);

	import chan_pkg::*;

	header_t hdr_q;                                     // header of the current fill

	//////////////////////////////////////////////////
	// fill number

	// host load beats the increment if both land together
	always_ff @(posedge clk) begin
		if (rst) begin
			fill_num <= '0;
		end else if (initial_fill_num_wr) begin
			fill_num <= acq_cfg.initial_fill_num;
		end else if (fill_done) begin
			fill_num <= fill_num + 1'b1;      // only on a completed readout
		end
	end

	//////////////////////////////////////////////////
	// header word

	// taken at the trigger so a later host write of
	// the fill number cannot change this fill
	always_ff @(posedge clk) begin
		if (hdr_capture) begin
			hdr_q.fill_num    <= fill_num;
			hdr_q.channel_tag <= acq_cfg.channel_tag;
			hdr_q.fill_type   <= fill_type;
			hdr_q.num_bursts  <= num_bursts;
			hdr_q.pad         <= '0;
		end
	end

	assign header = hdr_q;                              // flat 128 bit view

endmodule

/* rtl/readout_link.sv */
`timescale 1ns/1ps

module readout_link (
	input  logic            clk,
	input  logic            rst,
	input  chan_pkg::word_t word,             // buffer read data
	input  logic            word_req,         // fsm has a valid word
	input  logic            last_word,        // this word ends the fill
	input  logic            tx_ack,           // from the master
	output logic            word_ack,         // all parts of the word taken
	output chan_pkg::link_t tx_data,
	output logic            tx_req,
	output logic            tx_last           // final part of the fill
);

	import chan_pkg::*;

	localparam int PART_W = $clog2(PARTS_PER_WORD);

	typedef enum logic [1:0] {
		L_IDLE,                               // waiting for word_req
		L_REQ,                                // tx_req up, waiting for ack
		L_WAIT,                               // tx_req down, waiting for ack to drop
		L_ACK                                 // word_ack up, waiting for word_req to drop
	} link_state_t;

	link_state_t       lstate;
	logic [PART_W-1:0] part;                  // 0 is the top 32 bits
	logic              last_q;                // latched last_word
	word_t             word_q;                // word being sent
	logic              load;                  // take a new word

	assign load = (lstate == L_IDLE) && word_req;

	//////////////////////////////////////////////////
	// handshake sequencing

	always_ff @(posedge clk) begin
		if (rst) begin
			lstate <= L_IDLE;
			part   <= '0;
			last_q <= 1'b0;
		end else begin
			case (lstate)
				L_IDLE: if (load) begin
					part   <= '0;
					last_q <= last_word;
					lstate <= L_REQ;      // tx_req one cycle after word_req
				end
				L_REQ: if (tx_ack) begin
					lstate <= L_WAIT;     // master has the part
				end
				L_WAIT: if (!tx_ack) begin
					if (part == PART_W'(PARTS_PER_WORD - 1)) begin
						lstate <= L_ACK;  // whole word gone
					end else begin
						part   <= part + 1'b1;
						lstate <= L_REQ;
					end
				end
				L_ACK: if (!word_req) begin
					lstate <= L_IDLE;
				end
				default: lstate <= L_IDLE;
			endcase
		end
	end

	// payload only, no reset
	always_ff @(posedge clk) begin
		if (load) begin
			word_q <= word;
		end
	end

	//////////////////////////////////////////////////
	// outputs

	assign tx_req   = (lstate == L_REQ);
	assign word_ack = (lstate == L_ACK);
	assign tx_data  = word_q[WORD_W - 1 - int'(part) * LINK_W -: LINK_W]; // msb part first
	assign tx_last  = tx_req && last_q && (part == PART_W'(PARTS_PER_WORD - 1));

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the channel acquisition testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module channel_acq_tb -f sim.f -o channel_acq_sim
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

out="$(./obj_dir/channel_acq_sim)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "All tests passed"; then
	exit 0
fi
exit 1

/* sim.f */
rtl/chan_pkg.sv
rtl/burst_counter.sv
rtl/fill_buffer.sv
rtl/fill_header_gen.sv
rtl/readout_link.sv
rtl/acq_fsm.sv
rtl/channel_acq_top.sv
tests/channel_acq_props.sv
tests/channel_acq_tb.sv

/* tests/channel_acq_props.sv */
`timescale 1ns/1ps

module channel_acq_props (
	input logic            clk,
	input logic            rst,
	input logic            tx_req,
	input logic            tx_ack,
	input logic            tx_last,
	input chan_pkg::link_t tx_data
);

	//////////////////////////////////////////////////
	// four-phase tx handshake

	a_req_held: assert property (@(posedge clk) disable iff (rst)
		tx_req && !tx_ack |=> tx_req) else $error("tx_req dropped before tx_ack");

	a_data_stable: assert property (@(posedge clk) disable iff (rst)
		tx_req && !tx_ack |=> $stable(tx_data)) else $error("tx_data moved under tx_req");

	a_req_drops: assert property (@(posedge clk) disable iff (rst)
		tx_req && tx_ack |=> !tx_req) else $error("tx_req held after tx_ack");

	a_no_early_req: assert property (@(posedge clk) disable iff (rst)
		!tx_req && tx_ack |=> !tx_req) else $error("tx_req raised while tx_ack high");

	a_last_stable: assert property (@(posedge clk) disable iff (rst)
		tx_req && !tx_ack |=> $stable(tx_last)) else $error("tx_last moved under tx_req");

	// reset state
	a_reset_quiet: assert property (@(posedge clk)
		rst |=> !tx_req && !tx_last) else $error("tx_req or tx_last after reset");

endmodule

bind readout_link channel_acq_props i_link_props (.*);
bind channel_acq_top channel_acq_props i_top_props (.*);

/* tests/channel_acq_tb.sv */
`timescale 1ns/1ps

module channel_acq_tb;

	import chan_pkg::*;

	localparam int MAX_DLY = 3;                       // ack delay from two lfsr bits
	localparam int N_MUON  = 5;
	localparam int N_LASER = 3;
	localparam int N_PED   = 0;                       // header-only fill
	localparam int TOTAL_WORDS = 4 * (N_MUON + 1) + (N_LASER + 1) + (N_PED + 1) + N_MUON;
	localparam int TIMEOUT_CYCLES = TOTAL_WORDS * PARTS_PER_WORD * (2 * MAX_DLY + 6) + 2000;

	logic       clk;
	logic       rst;
	acq_cfg_t   acq_cfg;
	logic       initial_fill_num_wr;
	logic [1:0] acq_enable;
	logic       acq_trig;
	logic       acq_reset;
	logic       readout_pause;
	word_t      adc_data;
	logic       adc_valid;
	logic       acq_done;
	fill_num_t  fill_num;
	link_t      tx_data;
	logic       tx_req;
	logic       tx_last;
	logic       tx_ack = 1'b0;

	logic [15:0] data_lfsr = 16'd25940;              // stimulus samples and gaps
	logic [15:0] ack_lfsr  = 16'd25940;              // master ack delays
	logic [1:0]  dly_bits;
	int          ack_wait = 0;
	link_t       exp_data_q[$];
	logic        exp_last_q[$];
	link_t       got_data_q[$];
	logic        got_last_q[$];
	link_t       g_data, e_data;
	logic        g_last, e_last;
	int          n_got = 0;                           // parts taken by the master
	int          req_cycles = 0;
	int          done_cycles = 0;
	int          cycle = 0;
	int          errors = 0;
	int          cmp_errors = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	fill_num_t   model_fill_num;

	channel_acq_top #(.BUF_DEPTH(64)) i_dut (.*);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	//////////////////////////////////////////////////
	// reference model

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1); // galois, taps 16 14 13 11
	endfunction

	// header layout: fill number, tag, type, bursts, zero pad
	function automatic word_t ref_header(input fill_num_t fn, input tag_t tag,
			input logic [1:0] ftype, input burst_cnt_t nb);
		ref_header = {fn, tag, ftype, nb, 80'h0};
	endfunction

	task automatic take_bits(input int n, output word_t v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[126:0], data_lfsr[0]};
			data_lfsr = lfsr_step(data_lfsr);
		end
	endtask

	task automatic push_word(input word_t w, input logic last_word);
		for (int p = 0; p < PARTS_PER_WORD; p++) begin
			exp_data_q.push_back(w[127 - 32 * p -: 32]);      // msb part first
			exp_last_q.push_back(last_word && p == PARTS_PER_WORD - 1);
		end
	endtask

	//////////////////////////////////////////////////
	// master, monitor, compare

	always @(posedge clk) begin
		if (rst) begin
			tx_ack   <= 1'b0;
			ack_wait <= 0;
		end else if (tx_req && !tx_ack) begin
			if (ack_wait == 0) begin
				tx_ack <= 1'b1;
				got_data_q.push_back(tx_data);
				got_last_q.push_back(tx_last);
				n_got <= n_got + 1;
				dly_bits[0] = ack_lfsr[0];
				ack_lfsr = lfsr_step(ack_lfsr);
				dly_bits[1] = ack_lfsr[0];
				ack_lfsr = lfsr_step(ack_lfsr);
				ack_wait <= int'(dly_bits);           // delay for the next part
			end else begin
				ack_wait <= ack_wait - 1;
			end
		end else if (!tx_req && tx_ack) begin
			tx_ack <= 1'b0;
		end
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (tx_req) req_cycles <= req_cycles + 1;
		if (acq_done) done_cycles <= done_cycles + 1;
		if (cycle >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, the readout never completed", cycle);
			$display("Some tests failed");
			$finish;
		end
	end

	// compares on the falling edge, once the master has pushed
	always @(negedge clk) begin
		while (got_data_q.size() > 0) begin
			g_data = got_data_q.pop_front();
			g_last = got_last_q.pop_front();
			if (exp_data_q.size() == 0) begin
				$display("a part arrived when none was expected");
				cmp_errors++;
			end else begin
				e_data = exp_data_q.pop_front();
				e_last = exp_last_q.pop_front();
				assert (g_data == e_data) else begin
					$display("Fail tx_data: got %h expected %h", g_data, e_data);
					cmp_errors++;
				end
				assert (g_last == e_last) else begin
					$display("Fail tx_last: got %h expected %h", g_last, e_last);
					cmp_errors++;
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// test steps

	task automatic check_fill_num(input fill_num_t expv);
		assert (fill_num == expv) else begin
			$display("Fail fill_num: got %h expected %h", fill_num, expv);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		tests_run++;
		if (errors + cmp_errors > err_before) begin
			tests_failed++;
			$display("test %s FAILED", name);
		end else begin
			$display("test %s ok", name);
		end
	endtask

	task automatic run_fill(input logic [1:0] ftype, input int nb, input bit pause_mid);
		word_t s;
		int    got_base;
		int    held;
		int    taken;
		push_word(ref_header(model_fill_num, acq_cfg.channel_tag, ftype, burst_cnt_t'(nb)),
			nb == 0);
		got_base = n_got;
		@(posedge clk);
		acq_enable <= ftype;
		acq_trig   <= 1'b1;
		@(posedge clk);
		acq_trig <= 1'b0;
		taken = 0;
		while (taken < nb) begin
			@(posedge clk);
			take_bits(1, s);                       // random gap between bursts
			if (s[0]) begin
				take_bits(128, s);
				adc_data  <= s;
				adc_valid <= 1'b1;
				push_word(s, taken == nb - 1);
				taken++;
			end else begin
				adc_valid <= 1'b0;
			end
		end
		@(posedge clk);
		adc_valid <= 1'b0;                         // last word lands on this edge
		@(posedge clk);
		assert (acq_done) else begin
			$display("Fail acq_done: got %h expected %h", acq_done, 1'b1);
			errors++;
		end
		if (pause_mid) begin
			while (n_got - got_base < 2) @(posedge clk);
			readout_pause <= 1'b1;
			// word in flight finishes
			while ((n_got - got_base) % PARTS_PER_WORD != 0) @(posedge clk);
			held = n_got;
			repeat (30) @(posedge clk);
			assert (n_got == held) else begin
				$display("a new word started while readout_pause was high");
				errors++;
			end
			readout_pause <= 1'b0;
		end
		while (n_got - got_base < (nb + 1) * PARTS_PER_WORD) @(posedge clk);
		while (acq_done) @(posedge clk);           // falls with the fill number step
		model_fill_num = model_fill_num + 1'b1;
		check_fill_num(model_fill_num);
		assert (exp_data_q.size() == 0) else begin
			$display("parts still expected after the fill closed");
			errors++;
		end
	endtask

	//////////////////////////////////////////////////
	// main sequence

	initial begin
		int   e0;
		int   req0;
		int   done0;
		word_t s;
		rst                          = 1'b1;
		acq_cfg.channel_tag          = 16'hC3A5;
		acq_cfg.num_muon_bursts      = burst_cnt_t'(N_MUON);
		acq_cfg.num_laser_bursts     = burst_cnt_t'(N_LASER);
		acq_cfg.num_ped_bursts       = burst_cnt_t'(N_PED);
		acq_cfg.initial_fill_num     = 24'h001F40;
		initial_fill_num_wr          = 1'b0;
		acq_enable                   = 2'd0;
		acq_trig                     = 1'b0;
		acq_reset                    = 1'b0;
		readout_pause                = 1'b0;
		adc_data                     = '0;
		adc_valid                    = 1'b0;
		model_fill_num               = '0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);

		// reset state and a disabled trigger
		e0 = errors + cmp_errors;
		assert (!acq_done && !tx_req && !tx_last) else begin
			$display("outputs not idle after reset");
			errors++;
		end
		check_fill_num('0);
		req0  = req_cycles;
		done0 = done_cycles;
		acq_trig <= 1'b1;
		@(posedge clk);
		acq_trig <= 1'b0;
		repeat (10) @(posedge clk);
		assert (req_cycles == req0 && done_cycles == done0) else begin
			$display("a trigger with acq_enable 0 started a fill");
			errors++;
		end
		check_fill_num('0);
		report_test("reset_and_disabled", e0);

		e0 = errors + cmp_errors;
		run_fill(2'd1, N_MUON, 1'b0);
		report_test("muon_fill", e0);

		e0 = errors + cmp_errors;
		run_fill(2'd2, N_LASER, 1'b0);
		run_fill(2'd3, N_PED, 1'b0);
		report_test("laser_and_pedestal", e0);

		e0 = errors + cmp_errors;
		@(posedge clk);
		initial_fill_num_wr <= 1'b1;
		@(posedge clk);
		initial_fill_num_wr <= 1'b0;
		repeat (2) @(posedge clk);
		model_fill_num = acq_cfg.initial_fill_num;
		check_fill_num(model_fill_num);
		run_fill(2'd1, N_MUON, 1'b0);
		report_test("fill_number_load", e0);

		e0 = errors + cmp_errors;
		run_fill(2'd1, N_MUON, 1'b1);
		report_test("readout_pause", e0);

		// abort in the middle of capture
		e0 = errors + cmp_errors;
		req0  = req_cycles;
		done0 = done_cycles;
		@(posedge clk);
		acq_enable <= 2'd1;
		acq_trig   <= 1'b1;
		@(posedge clk);
		acq_trig <= 1'b0;
		repeat (2) begin
			@(posedge clk);
			take_bits(128, s);
			adc_data  <= s;
			adc_valid <= 1'b1;
		end
		@(posedge clk);
		acq_reset <= 1'b1;                         // bursts keep coming through the abort
		repeat (N_MUON) begin
			take_bits(128, s);
			adc_data <= s;
			@(posedge clk);
			acq_reset <= 1'b0;
		end
		adc_valid <= 1'b0;
		repeat (20) @(posedge clk);
		assert (req_cycles == req0 && done_cycles == done0) else begin
			$display("aborted fill still raised acq_done or tx_req");
			errors++;
		end
		check_fill_num(model_fill_num);
		run_fill(2'd1, N_MUON, 1'b0);
		report_test("abort_then_fill", e0);

		$display("tests run %0d, failed %0d, check errors %0d",
			tests_run, tests_failed, errors + cmp_errors);
		if (errors + cmp_errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule
